// ==== source/lc4_pkg.sv ====
`default_nettype none

package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;

    // one-hot negative, zero, positive
    typedef logic [2:0]  nzp_t;

    // why a trace record carries no work
    typedef logic [1:0]  stall_t;

    localparam stall_t STALL_NONE   = 2'd0;
    localparam stall_t STALL_BRANCH = 2'd2;
    localparam stall_t STALL_LOAD   = 2'd3;

    // opcode families in insn[15:12]
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;
    localparam logic [3:0] OP_JMP   = 4'b1100;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     is_jmp;
        word_t    insn;
    } ctrl_t;

    // in memory and writeback, a holds the result and b the store data
    typedef struct packed {
        ctrl_t  ctrl;
        word_t  pc;
        stall_t stall;
        word_t  a;
        word_t  b;
    } stage_t;

    typedef struct packed {
        logic     we;
        reg_sel_t rd;
        word_t    data;
    } fwd_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        stall_t   stall;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_sel_t wsel;
        word_t    wdata;
        logic     nzp_we;
        nzp_t     nzp;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
    } trace_t;

    function automatic nzp_t nzp_of(input word_t w);
        if (w[15]) begin
            return 3'b100;
        end else if (w == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

endpackage

`default_nettype wire

// ==== source/lc4_regfile.sv ====
`default_nettype none

module lc4_regfile (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::reg_sel_t  i_rs,
    input  wire lc4_pkg::reg_sel_t  i_rt,
    output lc4_pkg::word_t          o_rs_data,
    output lc4_pkg::word_t          o_rt_data,
    input  wire lc4_pkg::fwd_t      i_w_fwd
);

    lc4_pkg::word_t regs [8];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_w_fwd.we) begin
            regs[i_w_fwd.rd] <= i_w_fwd.data;
        end
    end

    // a write in this cycle is visible to a read of the same register
    always_comb begin
        o_rs_data = regs[i_rs];
        o_rt_data = regs[i_rt];
        if (i_w_fwd.we && i_w_fwd.rd == i_rs) begin
            o_rs_data = i_w_fwd.data;
        end
        if (i_w_fwd.we && i_w_fwd.rd == i_rt) begin
            o_rt_data = i_w_fwd.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/lc4_decode.sv ====
`default_nettype none

module lc4_decode (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::word_t     i_insn,
    input  wire lc4_pkg::word_t     i_pc,
    input  wire lc4_pkg::redirect_t i_redirect,
    input  wire lc4_pkg::fwd_t      i_w_fwd,
    output logic                    o_stall,
    output lc4_pkg::stage_t         o_dx
);

    lc4_pkg::word_t  f_insn;
    lc4_pkg::word_t  f_pc;
    lc4_pkg::stall_t f_stall;
    lc4_pkg::ctrl_t  ctrl;
    lc4_pkg::word_t  rs_data;
    lc4_pkg::word_t  rt_data;

    function automatic lc4_pkg::ctrl_t decode_insn(input lc4_pkg::word_t insn);
        lc4_pkg::ctrl_t c;
        c      = '0;
        c.insn = insn;
        c.rs   = insn[8:6];
        c.rt   = insn[2:0];
        c.rd   = insn[11:9];
        case (insn[15:12])
            lc4_pkg::OP_ARITH: begin
                // add-immediate, add and sub only
                if (insn[5] || insn[4:3] == 2'b00 || insn[4:3] == 2'b10) begin
                    c.rs_re  = 1'b1;
                    c.rt_re  = !insn[5];
                    c.rf_we  = 1'b1;
                    c.nzp_we = 1'b1;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                if (!insn[5]) begin
                    c.rs_re  = 1'b1;
                    c.rt_re  = (insn[4:3] != 2'b01);
                    c.rf_we  = 1'b1;
                    c.nzp_we = 1'b1;
                end
            end
            lc4_pkg::OP_CONST: begin
                c.rf_we  = 1'b1;
                c.nzp_we = 1'b1;
            end
            lc4_pkg::OP_LDR: begin
                c.rs_re   = 1'b1;
                c.rf_we   = 1'b1;
                c.nzp_we  = 1'b1;
                c.is_load = 1'b1;
            end
            lc4_pkg::OP_STR: begin
                // store data register sits in the rd field
                c.rt       = insn[11:9];
                c.rs_re    = 1'b1;
                c.rt_re    = 1'b1;
                c.is_store = 1'b1;
            end
            lc4_pkg::OP_BR: c.is_branch = (insn[11:9] != 3'b000);
            lc4_pkg::OP_JMP: c.is_jmp = insn[11];
            default: ;
        endcase
        return c;
    endfunction

    // fetch latch holds during a load-use stall
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            f_insn  <= '0;
            f_pc    <= '0;
            f_stall <= lc4_pkg::STALL_BRANCH;
        end else if (i_redirect.taken) begin
            f_insn  <= '0;
            f_pc    <= i_pc;
            f_stall <= lc4_pkg::STALL_BRANCH;
        end else if (!o_stall) begin
            f_insn  <= i_insn;
            f_pc    <= i_pc;
            f_stall <= lc4_pkg::STALL_NONE;
        end
    end

    assign ctrl = decode_insn(f_insn);

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (ctrl.rs),
        .i_rt      (ctrl.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_w_fwd   (i_w_fwd)
    );

    // load in execute feeding this instruction, or a branch needing its NZP
    assign o_stall = o_dx.ctrl.is_load &&
                     ((ctrl.rs_re && ctrl.rs == o_dx.ctrl.rd) ||
                      (ctrl.rt_re && ctrl.rt == o_dx.ctrl.rd) ||
                      ctrl.is_branch);

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dx       <= '0;
            o_dx.stall <= lc4_pkg::STALL_BRANCH;
        end else begin
            o_dx.pc <= f_pc;
            o_dx.a  <= rs_data;
            o_dx.b  <= rt_data;
            if (i_redirect.taken) begin
                o_dx.ctrl  <= '0;
                o_dx.stall <= lc4_pkg::STALL_BRANCH;
            end else if (o_stall) begin
                o_dx.ctrl  <= '0;
                o_dx.stall <= lc4_pkg::STALL_LOAD;
            end else begin
                o_dx.ctrl  <= ctrl;
                o_dx.stall <= f_stall;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/lc4_execute.sv ====
`default_nettype none

module lc4_execute (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::stage_t    i_dx,
    input  wire lc4_pkg::fwd_t      i_m_fwd,
    input  wire lc4_pkg::fwd_t      i_w_fwd,
    output lc4_pkg::redirect_t      o_redirect,
    output lc4_pkg::stage_t         o_xm
);

    lc4_pkg::word_t insn;
    lc4_pkg::word_t rs_val;
    lc4_pkg::word_t rt_val;
    lc4_pkg::word_t alu;
    lc4_pkg::word_t pc_offset;
    lc4_pkg::nzp_t  nzp_q;
    logic           br_taken;

    // the younger write wins so memory comes before writeback
    function automatic lc4_pkg::word_t fwd_sel(
        input lc4_pkg::fwd_t     m,
        input lc4_pkg::fwd_t     w,
        input lc4_pkg::reg_sel_t r,
        input lc4_pkg::word_t    latched
    );
        if (m.we && m.rd == r) begin
            return m.data;
        end else if (w.we && w.rd == r) begin
            return w.data;
        end
        return latched;
    endfunction

    assign insn   = i_dx.ctrl.insn;
    assign rs_val = fwd_sel(i_m_fwd, i_w_fwd, i_dx.ctrl.rs, i_dx.a);
    assign rt_val = fwd_sel(i_m_fwd, i_w_fwd, i_dx.ctrl.rt, i_dx.b);

    always_comb begin
        alu = '0;
        case (insn[15:12])
            lc4_pkg::OP_ARITH: begin
                if (insn[5]) begin
                    alu = rs_val + {{11{insn[4]}}, insn[4:0]};
                end else if (insn[4:3] == 2'b10) begin
                    alu = rs_val - rt_val;
                end else begin
                    alu = rs_val + rt_val;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                case (insn[4:3])
                    2'b00:   alu = rs_val & rt_val;
                    2'b01:   alu = ~rs_val;
                    2'b10:   alu = rs_val | rt_val;
                    default: alu = rs_val ^ rt_val;
                endcase
            end
            lc4_pkg::OP_CONST: alu = {{7{insn[8]}}, insn[8:0]};
            // effective address is base plus signed 6-bit offset
            lc4_pkg::OP_LDR, lc4_pkg::OP_STR: alu = rs_val + {{10{insn[5]}}, insn[5:0]};
            default: alu = '0;
        endcase
    end

    // jump uses an 11-bit offset, branch a 9-bit one
    assign pc_offset = i_dx.ctrl.is_jmp ? {{5{insn[10]}}, insn[10:0]}
                                        : {{7{insn[8]}}, insn[8:0]};

    assign br_taken = i_dx.ctrl.is_branch && ((nzp_q & insn[11:9]) != 3'b000);

    assign o_redirect.taken  = br_taken || i_dx.ctrl.is_jmp;
    assign o_redirect.target = i_dx.pc + 16'd1 + pc_offset;

    // a load sets NZP one stage later, from the memory forward; every
    // register writer also sets NZP, so a non-load there rewrites its own value
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzp_q <= lc4_pkg::nzp_of('0);
        end else if (i_dx.ctrl.nzp_we && !i_dx.ctrl.is_load) begin
            nzp_q <= lc4_pkg::nzp_of(alu);
        end else if (i_m_fwd.we) begin
            nzp_q <= lc4_pkg::nzp_of(i_m_fwd.data);
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_xm       <= '0;
            o_xm.stall <= lc4_pkg::STALL_BRANCH;
        end else begin
            o_xm.ctrl  <= i_dx.ctrl;
            o_xm.pc    <= i_dx.pc;
            o_xm.stall <= i_dx.stall;
            o_xm.a     <= alu;
            // store data after bypassing
            o_xm.b     <= rt_val;
        end
    end

endmodule

`default_nettype wire

// ==== source/lc4_result.sv ====
`default_nettype none

module lc4_result (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    input  wire lc4_pkg::stage_t    i_xm,
    input  wire lc4_pkg::word_t     i_dmem_rdata,
    output lc4_pkg::dmem_req_t      o_dmem,
    output lc4_pkg::fwd_t           o_m_fwd,
    output lc4_pkg::fwd_t           o_w_fwd,
    output lc4_pkg::trace_t         o_trace
);

    lc4_pkg::stage_t w_q;
    lc4_pkg::word_t  w_addr;
    lc4_pkg::word_t  st_data;
    lc4_pkg::word_t  m_data;
    lc4_pkg::word_t  mem_addr;
    logic            mem_op;

    assign mem_op   = i_xm.ctrl.is_load | i_xm.ctrl.is_store;
    assign mem_addr = mem_op ? i_xm.a : '0;

    // writeback still in flight to the store's data register
    assign st_data = (o_w_fwd.we && o_w_fwd.rd == i_xm.ctrl.rt) ? o_w_fwd.data : i_xm.b;

    assign o_dmem = '{we: i_xm.ctrl.is_store, addr: mem_addr, wdata: st_data};

    assign m_data  = i_xm.ctrl.is_load ? i_dmem_rdata : i_xm.a;
    assign o_m_fwd = '{we: i_xm.ctrl.rf_we, rd: i_xm.ctrl.rd, data: m_data};

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            w_q       <= '0;
            w_q.stall <= lc4_pkg::STALL_BRANCH;
        end else begin
            w_q.ctrl  <= i_xm.ctrl;
            w_q.pc    <= i_xm.pc;
            w_q.stall <= i_xm.stall;
            w_q.a     <= m_data;
            w_q.b     <= st_data;
        end
    end

    // address of the access now in writeback
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            w_addr <= '0;
        end else begin
            w_addr <= mem_addr;
        end
    end

    assign o_w_fwd = '{we: w_q.ctrl.rf_we, rd: w_q.ctrl.rd, data: w_q.a};

    always_comb begin
        o_trace.stall     = w_q.stall;
        o_trace.pc        = w_q.pc;
        o_trace.insn      = w_q.ctrl.insn;
        o_trace.rf_we     = w_q.ctrl.rf_we;
        o_trace.wsel      = w_q.ctrl.rf_we ? w_q.ctrl.rd : '0;
        o_trace.wdata     = w_q.ctrl.rf_we ? w_q.a : '0;
        o_trace.nzp_we    = w_q.ctrl.nzp_we;
        o_trace.nzp       = w_q.ctrl.nzp_we ? lc4_pkg::nzp_of(w_q.a) : '0;
        o_trace.dmem_we   = w_q.ctrl.is_store;
        o_trace.dmem_addr = (w_q.ctrl.is_load || w_q.ctrl.is_store) ? w_addr : '0;
        // loads report the word read, stores the word written
        if (w_q.ctrl.is_load) begin
            o_trace.dmem_data = w_q.a;
        end else if (w_q.ctrl.is_store) begin
            o_trace.dmem_data = w_q.b;
        end else begin
            o_trace.dmem_data = '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/lc4_core.sv ====
`default_nettype none

module lc4_core #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  wire                     gwe,
    input  wire                     i_rst_n,
    output lc4_pkg::word_t          o_cur_pc,
    input  wire lc4_pkg::word_t     i_cur_insn,
    output lc4_pkg::dmem_req_t      o_dmem,
    input  wire lc4_pkg::word_t     i_dmem_rdata,
    output lc4_pkg::trace_t         o_trace
);

    lc4_pkg::word_t     pc_q;
    lc4_pkg::word_t     next_pc;
    logic               stall;
    lc4_pkg::redirect_t redirect;
    lc4_pkg::stage_t    dx;
    lc4_pkg::stage_t    xm;
    lc4_pkg::fwd_t      m_fwd;
    lc4_pkg::fwd_t      w_fwd;

    // hold on a load-use stall, otherwise follow execute or step by one
    always_comb begin
        if (stall) begin
            next_pc = pc_q;
        end else if (redirect.taken) begin
            next_pc = redirect.target;
        end else begin
            next_pc = pc_q + 16'd1;
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign o_cur_pc = pc_q;

    lc4_decode u_decode (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_insn     (i_cur_insn),
        .i_pc       (pc_q),
        .i_redirect (redirect),
        .i_w_fwd    (w_fwd),
        .o_stall    (stall),
        .o_dx       (dx)
    );

    lc4_execute u_execute (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_dx       (dx),
        .i_m_fwd    (m_fwd),
        .i_w_fwd    (w_fwd),
        .o_redirect (redirect),
        .o_xm       (xm)
    );

    lc4_result u_result (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_xm         (xm),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem       (o_dmem),
        .o_m_fwd      (m_fwd),
        .o_w_fwd      (w_fwd),
        .o_trace      (o_trace)
    );

endmodule

`default_nettype wire

// ==== tests/lc4_core_chk.sv ====
`default_nettype none

module lc4_core_chk (
    input wire                     gwe,
    input wire                     i_rst_n,
    input wire lc4_pkg::word_t     i_pc,
    input wire                     i_stall,
    input wire lc4_pkg::redirect_t i_redirect,
    input wire lc4_pkg::stage_t    i_xm,
    input wire lc4_pkg::dmem_req_t i_dmem
);

    // a store may only leave memory for a real instruction
    a_no_bubble_store: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        i_dmem.we |-> i_xm.stall == lc4_pkg::STALL_NONE
    ) else $error("memory write issued from a bubble");

    // the squash leaves no taken branch in execute next cycle
    a_redirect_pulse: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        i_redirect.taken |=> !i_redirect.taken
    ) else $error("redirect held for more than one cycle");

    a_pc_hold: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        i_stall |=> i_pc == $past(i_pc)
    ) else $error("pc moved during a load-use stall");

endmodule

`default_nettype wire

// ==== tests/lc4_core_tb.sv ====
`default_nettype none

bind lc4_core lc4_core_chk u_chk (
    .gwe        (gwe),
    .i_rst_n    (i_rst_n),
    .i_pc       (pc_q),
    .i_stall    (stall),
    .i_redirect (redirect),
    .i_xm       (xm),
    .i_dmem     (o_dmem)
);

module lc4_core_tb;

    logic                gwe;
    logic                i_rst_n;
    lc4_pkg::word_t      o_cur_pc;
    lc4_pkg::word_t      i_cur_insn;
    lc4_pkg::dmem_req_t  o_dmem;
    lc4_pkg::word_t      i_dmem_rdata;
    lc4_pkg::trace_t     o_trace;

    lc4_pkg::word_t      dmem [256];
    lc4_pkg::trace_t     exp_tr [$];
    lc4_pkg::dmem_req_t  exp_wr [$];
    int                  wr_idx;
    logic                wr_pend;
    lc4_pkg::dmem_req_t  wr_req;
    int                  trace_errs;
    int                  dmem_errs;
    int                  other_errs;
    int                  cycles;

    // program at 0x8200; entries 16, 18 and 19 must be squashed
    localparam lc4_pkg::word_t prog_rom [24] = '{
        16'h9205, 16'h95FD, 16'h1642, 16'h18D1, 16'h1B23, 16'h5C44,
        16'h5F92, 16'h51D9, 16'h9C20, 16'h5A08, 16'h7B81, 16'h6381,
        16'h1441, 16'h6781, 16'h0405, 16'h0201, 16'h9001, 16'hC802,
        16'h9001, 16'h9001, 16'h18FF, 16'h0801, 16'h7982, 16'h6F82
    };

    lc4_core #(
        .RESET_PC (16'h8200)
    ) i_lc4_core (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .o_cur_pc     (o_cur_pc),
        .i_cur_insn   (i_cur_insn),
        .o_dmem       (o_dmem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_trace      (o_trace)
    );

    function automatic lc4_pkg::word_t fetch_word(input lc4_pkg::word_t pc);
        lc4_pkg::word_t idx;
        idx = pc - 16'h8200;
        if (idx < 16'd24) begin
            return prog_rom[idx[4:0]];
        end
        return 16'h0000;
    endfunction

    assign i_cur_insn   = fetch_word(o_cur_pc);
    assign i_dmem_rdata = dmem[o_dmem.addr[7:0]];

    initial begin
        gwe = 1'b0;
        forever #50 gwe = ~gwe;
    end

    function automatic lc4_pkg::nzp_t exp_nzp(input lc4_pkg::word_t v);
        return {v[15], v == 16'h0000, !v[15] && v != 16'h0000};
    endfunction

    function automatic lc4_pkg::trace_t nop_rec(input int idx, input lc4_pkg::word_t insn);
        lc4_pkg::trace_t r;
        r       = '0;
        r.stall = lc4_pkg::STALL_NONE;
        r.pc    = 16'h8200 + idx[15:0];
        r.insn  = insn;
        return r;
    endfunction

    function automatic lc4_pkg::trace_t alu_rec(input int idx, input lc4_pkg::word_t insn,
                                                input lc4_pkg::reg_sel_t rd,
                                                input lc4_pkg::word_t val);
        lc4_pkg::trace_t r;
        r        = nop_rec(idx, insn);
        r.rf_we  = 1'b1;
        r.wsel   = rd;
        r.wdata  = val;
        r.nzp_we = 1'b1;
        r.nzp    = exp_nzp(val);
        return r;
    endfunction

    function automatic lc4_pkg::trace_t ld_rec(input int idx, input lc4_pkg::word_t insn,
                                               input lc4_pkg::reg_sel_t rd,
                                               input lc4_pkg::word_t addr,
                                               input lc4_pkg::word_t val);
        lc4_pkg::trace_t r;
        r           = alu_rec(idx, insn, rd, val);
        r.dmem_addr = addr;
        r.dmem_data = val;
        return r;
    endfunction

    function automatic lc4_pkg::trace_t st_rec(input int idx, input lc4_pkg::word_t insn,
                                               input lc4_pkg::word_t addr,
                                               input lc4_pkg::word_t val);
        lc4_pkg::trace_t r;
        r           = nop_rec(idx, insn);
        r.dmem_we   = 1'b1;
        r.dmem_addr = addr;
        r.dmem_data = val;
        return r;
    endfunction

    function automatic lc4_pkg::trace_t bub_rec(input lc4_pkg::stall_t code);
        lc4_pkg::trace_t r;
        r       = '0;
        r.stall = code;
        return r;
    endfunction

    // a bubble is compared on its code and write enables alone
    task automatic check_trace(input lc4_pkg::trace_t got, input lc4_pkg::trace_t exp,
                               input int n);
        logic bad;
        if (exp.stall != lc4_pkg::STALL_NONE) begin
            bad = got.stall !== exp.stall || got.rf_we !== 1'b0 ||
                  got.nzp_we !== 1'b0 || got.dmem_we !== 1'b0;
        end else begin
            bad = got !== exp;
        end
        if (bad) begin
            trace_errs++;
            $display("CHECK FAILED t=%0t: trace %0d got %h expected %h", $time, n, got, exp);
        end
    endtask

    task automatic check_dmem(input lc4_pkg::dmem_req_t got);
        if (wr_idx >= exp_wr.size()) begin
            dmem_errs++;
            $display("t=%0t: unexpected memory write to %h", $time, got.addr);
        end else if (got !== exp_wr[wr_idx]) begin
            dmem_errs++;
            $display("CHECK FAILED t=%0t: write %0d got %h expected %h",
                     $time, wr_idx, got, exp_wr[wr_idx]);
        end
        wr_idx++;
    endtask

    task automatic check_word(input lc4_pkg::word_t got, input lc4_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            other_errs++;
            $display("CHECK FAILED t=%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // the memory request is sampled mid-cycle and committed at the edge
    always @(negedge gwe) begin
        wr_pend = i_rst_n && o_dmem.we;
        wr_req  = o_dmem;
        if (wr_pend) begin
            check_dmem(o_dmem);
        end
    end

    always @(posedge gwe) begin
        if (wr_pend) begin
            dmem[wr_req.addr[7:0]] <= wr_req.wdata;
        end
    end

    initial begin
        i_rst_n    = 1'b0;
        wr_pend    = 1'b0;
        wr_req     = '0;
        wr_idx     = 0;
        trace_errs = 0;
        dmem_errs  = 0;
        other_errs = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = lc4_pkg::word_t'(i) * 16'h0107 ^ 16'h3C5A;
        end

        exp_tr.push_back(alu_rec(0, 16'h9205, 3'd1, 16'h0005));
        exp_tr.push_back(alu_rec(1, 16'h95FD, 3'd2, 16'hFFFD));
        exp_tr.push_back(alu_rec(2, 16'h1642, 3'd3, 16'h0002));
        exp_tr.push_back(alu_rec(3, 16'h18D1, 3'd4, 16'hFFFD));
        exp_tr.push_back(alu_rec(4, 16'h1B23, 3'd5, 16'h0000));
        exp_tr.push_back(alu_rec(5, 16'h5C44, 3'd6, 16'h0005));
        exp_tr.push_back(alu_rec(6, 16'h5F92, 3'd7, 16'hFFFD));
        exp_tr.push_back(alu_rec(7, 16'h51D9, 3'd0, 16'hFFF8));
        exp_tr.push_back(alu_rec(8, 16'h9C20, 3'd6, 16'h0020));
        exp_tr.push_back(alu_rec(9, 16'h5A08, 3'd5, 16'h0007));
        exp_tr.push_back(st_rec(10, 16'h7B81, 16'h0021, 16'h0007));
        exp_tr.push_back(ld_rec(11, 16'h6381, 3'd1, 16'h0021, 16'h0007));
        exp_tr.push_back(bub_rec(lc4_pkg::STALL_LOAD));
        exp_tr.push_back(alu_rec(12, 16'h1441, 3'd2, 16'h000E));
        exp_tr.push_back(ld_rec(13, 16'h6781, 3'd3, 16'h0021, 16'h0007));
        exp_tr.push_back(bub_rec(lc4_pkg::STALL_LOAD));
        exp_tr.push_back(nop_rec(14, 16'h0405));
        exp_tr.push_back(nop_rec(15, 16'h0201));
        exp_tr.push_back(bub_rec(lc4_pkg::STALL_BRANCH));
        exp_tr.push_back(bub_rec(lc4_pkg::STALL_BRANCH));
        exp_tr.push_back(nop_rec(17, 16'hC802));
        exp_tr.push_back(bub_rec(lc4_pkg::STALL_BRANCH));
        exp_tr.push_back(bub_rec(lc4_pkg::STALL_BRANCH));
        exp_tr.push_back(alu_rec(20, 16'h18FF, 3'd4, 16'h0006));
        exp_tr.push_back(nop_rec(21, 16'h0801));
        exp_tr.push_back(st_rec(22, 16'h7982, 16'h0022, 16'h0006));
        exp_tr.push_back(ld_rec(23, 16'h6F82, 3'd7, 16'h0022, 16'h0006));
        exp_wr.push_back('{we: 1'b1, addr: 16'h0021, wdata: 16'h0007});
        exp_wr.push_back('{we: 1'b1, addr: 16'h0022, wdata: 16'h0006});

        @(posedge gwe);
        @(negedge gwe);
        check_word(o_cur_pc, 16'h8200, "reset pc");
        check_word({15'd0, o_dmem.we}, 16'h0000, "reset dmem we");
        check_trace(o_trace, bub_rec(lc4_pkg::STALL_BRANCH), -1);
        repeat (7) @(posedge gwe);
        i_rst_n <= 1'b1;

        // pipeline fill shows only branch bubbles
        cycles = 0;
        @(negedge gwe);
        while (o_trace.stall != lc4_pkg::STALL_NONE && cycles < 20) begin
            check_trace(o_trace, bub_rec(lc4_pkg::STALL_BRANCH), -1);
            @(negedge gwe);
            cycles++;
        end
        if (cycles >= 20) begin
            $display("timeout: no instruction retired after reset");
            $display("Done: errors found");
            $finish;
        end else begin
            for (int i = 0; i < exp_tr.size(); i++) begin
                check_trace(o_trace, exp_tr[i], i);
                @(negedge gwe);
            end
            if (wr_idx != exp_wr.size()) begin
                dmem_errs++;
                $display("saw %0d memory writes, expected %0d", wr_idx, exp_wr.size());
            end
            $display("errors: trace %0d, dmem %0d, other %0d",
                     trace_errs, dmem_errs, other_errs);
            if (trace_errs + dmem_errs + other_errs == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/lc4_pkg.sv
source/lc4_regfile.sv
source/lc4_decode.sv
source/lc4_execute.sv
source/lc4_result.sv
source/lc4_core.sv
tests/lc4_core_chk.sv
tests/lc4_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lc4_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module lc4_core_tb \
    --Mdir obj_dir -o lc4_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/lc4_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1
